//--- lfbuf_top.f
+incdir+verilog
verilog/lfbuf_video_pkg.sv
verilog/lfbuf_psram_pkg.sv
verilog/lfbuf_hblank_timer.sv
verilog/lfbuf_line_ram.sv
verilog/lfbuf_psram_ctrl.sv
verilog/lfbuf_top.sv
tb/lfbuf_psram_model.sv
tb/lfbuf_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= lfbuf_tb
FILELIST  ?= lfbuf_top.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/lfbuf_tb.sv
/* line frame buffer testbench
   video timing, renderer, PSRAM model, burst and data checks */
`timescale 1ns/1ps
`include "lfbuf_settings.svh"

module lfbuf_tb;

    localparam int LINE_PX      = 672;              // pixels per line incl. blank
    localparam int ACTIVE_PX    = 512;
    localparam int LINES_TESTED = 2;                // lines written and read back
    localparam int MAX_CEN_LOW  = `LFBUF_CHUNK + `LFBUF_LATENCY + 4;
    localparam longint WATCHDOG_NS = (LINES_TESTED + 4) * LINE_PX * 4 * 8;

    logic clk, rst, pxl_cen, lhbl, ln_done, frame, fb_done, line, scan_busy;
    lfbuf_video_pkg::line_idx_t   ln_v, vrender;
    lfbuf_video_pkg::line_wr_t    ln_wr;
    lfbuf_video_pkg::pix_idx_t    scan_addr;
    lfbuf_video_pkg::pixel_t      scan_data;
    lfbuf_psram_pkg::psram_out_t  psram_out;
    lfbuf_psram_pkg::psram_in_t   psram_in;
    logic [21:0] cfg_reg;
    logic [17:0] peek_addr;
    logic [15:0] peek_data;
    int          wr_count;

    lfbuf_video_pkg::pixel_t exp_line [0:511];      // expected line contents
    int  div, hpos, cen_len, n_done, n_reads, wr_periods, rd_periods, cfg_periods;
    logic prev_cen, prev_busy, cen_is_wr, cen_is_cfg;

    lfbuf_top dut (.*);

    lfbuf_psram_model u_psram (.clk(clk), .rst(rst), .bus_out(psram_out), .bus_in(psram_in),
        .cfg_reg(cfg_reg), .wr_count(wr_count), .peek_addr(peek_addr), .peek_data(peek_data));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all transfers completed");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // mixing rule for rendered pixels
    function automatic lfbuf_video_pkg::pixel_t ref_pixel(logic f,
            lfbuf_video_pkg::line_idx_t ln, lfbuf_video_pkg::pix_idx_t x);
        return (16'(x) * 16'h9e37) ^ {ln, 8'(x)} ^ (f ? 16'h5a5a : 16'h0c3c);
    endfunction

    task automatic check_pixel(string name, lfbuf_video_pkg::pixel_t got,
            lfbuf_video_pkg::pixel_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_cfg(string name, logic [21:0] got, logic [21:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "config mismatch");
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // 4 clocks per pixel and blank after the active 512
    always @(posedge clk) begin : video_timing
        int nxt;
        nxt = (hpos == LINE_PX - 1) ? 0 : hpos + 1;
        div     <= (div + 1) % 4;
        pxl_cen <= (div == 3);
        if (pxl_cen) begin
            hpos <= nxt;
            lhbl <= (nxt < ACTIVE_PX);
        end
    end

    // bus and handshake monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (!psram_out.cen) begin
                if (prev_cen) begin                 // address cycle
                    cen_len    = 0;
                    cen_is_wr  = !psram_out.wen;
                    cen_is_cfg = psram_out.cre;
                end
                cen_len++;
                if (!psram_out.advn) begin          // address on the pad
                    check_flag("adq_oe", psram_out.adq_oe, 1'b1);
                end else if (!cen_is_cfg) begin     // pad driven only when writing
                    check_flag("adq_oe", psram_out.adq_oe, cen_is_wr);
                    check_flag("oen", psram_out.oen, cen_is_wr);
                end
            end else if (!prev_cen) begin
                check_flag($sformatf("cen low for %0d cycles", cen_len),
                           cen_len <= MAX_CEN_LOW, 1'b1);
                if (cen_is_cfg) cfg_periods++;
                else if (cen_is_wr) wr_periods++;
                else rd_periods++;
            end
            if (fb_done) begin
                n_done++;
                check_flag("line", line, n_done[0]);
            end
            if (prev_busy && !scan_busy) n_reads++;
            prev_cen  = psram_out.cen;
            prev_busy = scan_busy;
        end
    end

    // renderer writes a random subset of pixels below x_limit
    task automatic render_line(logic f, lfbuf_video_pkg::line_idx_t ln, int x_limit);
        logic sel;
        for (int x = 0; x < ACTIVE_PX; x++) begin
            sel = (($urandom % 4) != 0) && (x < x_limit);
            exp_line[9'(x)] = sel ? ref_pixel(f, ln, 9'(x)) : 16'h0000;
            @(posedge clk);
            ln_wr.addr <= 9'(x);
            ln_wr.data <= ref_pixel(f, ln, 9'(x));
            ln_wr.we   <= sel;
        end
        @(posedge clk);
        ln_wr.we <= 1'b0;
    endtask

    // power-up blanking of the render buffer
    task automatic zero_render();
        for (int x = 0; x < ACTIVE_PX; x++) begin
            @(posedge clk);
            ln_wr.addr <= 9'(x);
            ln_wr.data <= '0;
            ln_wr.we   <= 1'b1;
        end
        @(posedge clk);
        ln_wr.we <= 1'b0;
    endtask

    task automatic request_write(lfbuf_video_pkg::line_idx_t ln, int done_before);
        @(posedge clk);
        ln_v    <= ln;
        ln_done <= 1'b1;
        @(posedge clk);
        ln_done <= 1'b0;
        wait (n_done == done_before + 1);
        repeat (ACTIVE_PX + 4) @(posedge clk);      // background clear
    endtask

    task automatic check_bank(logic bank, lfbuf_video_pkg::line_idx_t ln);
        for (int x = 0; x < ACTIVE_PX; x++) begin
            @(posedge clk);
            peek_addr <= {bank, ln, 9'(x)};
            @(negedge clk);
            check_pixel($sformatf("psram row %0d col %0d", ln, x), peek_data, exp_line[9'(x)]);
        end
    endtask

    task automatic check_scan();
        for (int x = 0; x < ACTIVE_PX; x++) begin
            @(posedge clk);
            scan_addr <= 9'(x);
            @(posedge clk);
            @(negedge clk);
            check_pixel($sformatf("scan_data col %0d", x), scan_data, exp_line[9'(x)]);
        end
    endtask

    initial begin
        void'($urandom(81));
        rst = 1'b1;
        pxl_cen = 1'b0;
        lhbl = 1'b1;
        ln_done = 1'b0;
        frame = 1'b0;
        ln_v = '0;
        vrender = '0;
        ln_wr = '0;
        scan_addr = '0;
        peek_addr = '0;
        div = 0;
        hpos = 0;
        cen_len = 0;
        n_done = 0;
        n_reads = 0;
        wr_periods = 0;
        rd_periods = 0;
        cfg_periods = 0;
        prev_cen = 1'b1;
        prev_busy = 1'b0;
        cen_is_wr = 1'b0;
        cen_is_cfg = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);                             // outputs held by reset
        check_flag("cen", psram_out.cen, 1'b1);
        check_flag("advn", psram_out.advn, 1'b1);
        check_flag("oen", psram_out.oen, 1'b1);
        check_flag("wen", psram_out.wen, 1'b1);
        check_flag("fb_done", fb_done, 1'b0);
        check_flag("scan_busy", scan_busy, 1'b0);
        check_flag("line", line, 1'b0);
        @(posedge clk);
        rst <= 1'b0;
        wait (rd_periods >= 1);                     // config and dummy read done
        @(negedge clk);
        check_cfg("bcr", cfg_reg, lfbuf_psram_pkg::BCR_WORD);
        check_flag("no array write before dummy read", wr_count == 0, 1'b1);
        check_flag("cfg accesses", cfg_periods == 1, 1'b1);
        zero_render();
        render_line(1'b0, 8'd37, ACTIVE_PX);
        request_write(8'd37, 0);
        check_bank(1'b1, 8'd37);
        @(posedge clk);
        frame   <= 1'b1;
        vrender <= 8'd37;
        wait (!scan_busy);
        @(posedge scan_busy);
        @(negedge scan_busy);
        wait (lhbl);
        check_scan();
        @(posedge clk);
        frame <= 1'b0;
        render_line(1'b0, 8'd38, 200);              // shorter line over a cleared buffer
        request_write(8'd38, 1);
        check_bank(1'b1, 8'd38);
        @(negedge scan_busy);
        repeat (2) @(negedge clk);
        check_flag("two lines written", n_done == 2, 1'b1);
        check_flag("write bursts per line", wr_periods == 4 * n_done, 1'b1);
        check_flag("read bursts per line", rd_periods == 1 + 4 * n_reads, 1'b1);
        $display("Test passed");
        $finish;
    end

endmodule

//--- tb/lfbuf_psram_model.sv
/* behavioural PSRAM for the line frame buffer testbench
   config register, line storage, wait after fixed latency */
`timescale 1ns/1ps
`include "lfbuf_settings.svh"

module lfbuf_psram_model (
    input  logic                         clk,
    input  logic                         rst,
    input  lfbuf_psram_pkg::psram_out_t  bus_out,
    output lfbuf_psram_pkg::psram_in_t   bus_in,
    output logic [21:0]                  cfg_reg,
    output int                           wr_count,
    input  logic [17:0]                  peek_addr,
    output logic [15:0]                  peek_data
);

    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_DATA} model_state_t;

    logic [15:0]  mem [0:(1<<18)-1];                // bank, row, column only
    logic [21:0]  addr;                             // running word address
    logic         is_wr;
    logic         is_cfg;
    int           lat_cnt;
    model_state_t ms;

    // row gap bits are always zero, drop them
    function automatic logic [17:0] word_index(logic [21:0] a);
        return {a[21:13], a[8:0]};
    endfunction

    assign peek_data = mem[peek_addr];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ms            <= M_IDLE;
            bus_in.wait_n <= 1'b0;
            bus_in.adq    <= '0;
            cfg_reg       <= '0;
            wr_count      <= 0;
            lat_cnt       <= 0;
            addr          <= '0;
            is_wr         <= 1'b0;
            is_cfg        <= 1'b0;
        end else if (bus_out.cen) begin             // deselected
            ms            <= M_IDLE;
            bus_in.wait_n <= 1'b0;
        end else begin
            case (ms)
                M_IDLE: if (!bus_out.advn) begin    // address phase
                    addr    <= {bus_out.addr_hi, bus_out.adq};
                    is_wr   <= !bus_out.wen;
                    is_cfg  <= bus_out.cre;
                    if (bus_out.cre && !bus_out.wen) begin
                        cfg_reg <= {bus_out.addr_hi, bus_out.adq};
                    end
                    lat_cnt <= 1;
                    ms      <= M_WAIT;
                end
                M_WAIT: begin
                    lat_cnt <= lat_cnt + 1;
                    if (lat_cnt == `LFBUF_LATENCY) bus_in.wait_n <= 1'b1;
                    if (bus_in.wait_n) begin        // controller saw ready
                        ms <= M_DATA;
                        if (!is_wr && !is_cfg) begin
                            bus_in.adq <= mem[word_index(addr)];
                            addr       <= addr + 22'd1;
                        end
                    end
                end
                M_DATA: if (!is_cfg) begin          // one word per clock
                    if (is_wr) begin
                        mem[word_index(addr)] <= bus_out.adq;
                        wr_count              <= wr_count + 1;
                    end else begin
                        bus_in.adq <= mem[word_index(addr)];
                    end
                    addr <= addr + 22'd1;
                end
                default: ms <= M_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/lfbuf_top.sv
/* line frame buffer top level
   blank timer, PSRAM controller, render and scan-out line RAMs */
`timescale 1ns/1ps

module lfbuf_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic                         lhbl,
    input  logic                         ln_done,
    input  logic                         frame,
    input  lfbuf_video_pkg::line_idx_t   ln_v,
    input  lfbuf_video_pkg::line_idx_t   vrender,
    input  lfbuf_video_pkg::line_wr_t    ln_wr,
    input  lfbuf_video_pkg::pix_idx_t    scan_addr,
    output lfbuf_video_pkg::pixel_t      scan_data,
    output lfbuf_psram_pkg::psram_out_t  psram_out,
    input  lfbuf_psram_pkg::psram_in_t   psram_in,
    output logic                         fb_done,
    output logic                         line,
    output logic                         scan_busy
);

    logic                      wr_window;
    logic                      blank_start;
    lfbuf_video_pkg::pix_idx_t fb_addr;             // render RAM read address
    lfbuf_video_pkg::pixel_t   fb_din;
    lfbuf_video_pkg::line_wr_t clr_wr;
    lfbuf_video_pkg::line_wr_t scan_wr;
    lfbuf_video_pkg::line_wr_t render_wr;           // merged render RAM port

    // clear takes the port over the renderer
    assign render_wr = clr_wr.we ? clr_wr : ln_wr;

    lfbuf_hblank_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .lhbl        (lhbl),
        .wr_window   (wr_window),
        .blank_start (blank_start)
    );

    lfbuf_psram_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .ln_done     (ln_done),
        .lhbl        (lhbl),
        .ln_v        (ln_v),
        .vrender     (vrender),
        .wr_window   (wr_window),
        .blank_start (blank_start),
        .fb_addr     (fb_addr),
        .fb_din      (fb_din),
        .clr_wr      (clr_wr),
        .scan_wr     (scan_wr),
        .fb_done     (fb_done),
        .line        (line),
        .scan_busy   (scan_busy),
        .psram_out   (psram_out),
        .psram_in    (psram_in)
    );

    // line being drawn by the renderer
    lfbuf_line_ram u_render_ram (
        .clk     (clk),
        .wr      (render_wr),
        .rd_addr (fb_addr),
        .rd_data (fb_din)
    );

    // line being shown
    lfbuf_line_ram u_scan_ram (
        .clk     (clk),
        .wr      (scan_wr),
        .rd_addr (scan_addr),
        .rd_data (scan_data)
    );

endmodule

//--- verilog/lfbuf_psram_ctrl.sv
/* PSRAM line transfer controller
   configures the device, bursts rendered lines out, reads display lines back
   and clears the render buffer after each write */
`timescale 1ns/1ps
`include "lfbuf_settings.svh"

module lfbuf_psram_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         frame,
    input  logic                         ln_done,
    input  logic                         lhbl,
    input  lfbuf_video_pkg::line_idx_t   ln_v,
    input  lfbuf_video_pkg::line_idx_t   vrender,
    input  logic                         wr_window,
    input  logic                         blank_start,
    output lfbuf_video_pkg::pix_idx_t    fb_addr,
    input  lfbuf_video_pkg::pixel_t      fb_din,
    output lfbuf_video_pkg::line_wr_t    clr_wr,
    output lfbuf_video_pkg::line_wr_t    scan_wr,
    output logic                         fb_done,
    output logic                         line,
    output logic                         scan_busy,
    output lfbuf_psram_pkg::psram_out_t  psram_out,
    input  lfbuf_psram_pkg::psram_in_t   psram_in
);

    localparam int CW  = $clog2(`LFBUF_CHUNK);              // chunk counter bits
    localparam int PAD = 22 - 1 - `LFBUF_VW - `LFBUF_HW;    // gap between row and column

    lfbuf_psram_pkg::ctrl_state_t st;

    logic [21:0]                addr_r;             // full word address
    lfbuf_video_pkg::pix_idx_t  col;                // burst word counter
    lfbuf_video_pkg::line_idx_t wr_line;            // line awaiting write
    logic                       cen_r, advn_r, oen_r, wen_r, cre_r;
    logic                       fb_clr;             // background clear running
    logic                       do_wr, do_rd;       // pending requests
    logic                       ln_done_l;
    logic                       chunk_end, line_end;

    assign chunk_end = &col[CW-1:0];
    assign line_end  = &col;

    // bus outputs, adq carries the address on advn low and render data after
    always_comb begin
        psram_out.addr_hi = addr_r[21:16];
        psram_out.adq     = advn_r ? fb_din : addr_r[15:0];
        psram_out.adq_oe  = !cen_r && (!advn_r || !wen_r);
        psram_out.advn    = advn_r;
        psram_out.cen     = cen_r;
        psram_out.oen     = oen_r;
        psram_out.wen     = wen_r;
        psram_out.cre     = cre_r;
    end

    // clear port shares fb_addr, never active with a line write
    always_comb begin
        clr_wr.addr = fb_addr;
        clr_wr.data = '0;
        clr_wr.we   = fb_clr;
    end

    // read data lands in the scan RAM as it arrives
    always_comb begin
        scan_wr.addr = col;
        scan_wr.data = psram_in.adq;
        scan_wr.we   = (st == lfbuf_psram_pkg::ST_RD_BURST);
    end

    // line number captured with the request
    always_ff @(posedge clk) begin
        if (ln_done && !ln_done_l) begin
            wr_line <= ln_v;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= lfbuf_psram_pkg::ST_CFG;
            addr_r    <= '0;
            col       <= '0;
            cen_r     <= 1'b1;
            advn_r    <= 1'b1;
            oen_r     <= 1'b1;
            wen_r     <= 1'b1;
            cre_r     <= 1'b0;
            fb_addr   <= '0;
            fb_clr    <= 1'b0;
            fb_done   <= 1'b0;
            line      <= 1'b0;
            scan_busy <= 1'b0;
            do_wr     <= 1'b0;
            do_rd     <= 1'b0;
            ln_done_l <= 1'b0;
        end else begin
            fb_done   <= 1'b0;
            ln_done_l <= ln_done;
            if (blank_start) do_rd <= 1'b1;
            if (fb_clr) begin                       // one address per cycle
                fb_addr <= fb_addr + 1'b1;
                if (&fb_addr) fb_clr <= 1'b0;
            end
            case (st)
                lfbuf_psram_pkg::ST_CFG: begin
                    addr_r <= lfbuf_psram_pkg::BCR_WORD;
                    cen_r  <= 1'b0;
                    advn_r <= 1'b0;
                    cre_r  <= 1'b1;                 // register access
                    wen_r  <= 1'b0;
                    st     <= lfbuf_psram_pkg::ST_CFG_WAIT;
                end
                lfbuf_psram_pkg::ST_CFG_WAIT: begin
                    advn_r <= 1'b1;
                    cre_r  <= 1'b0;
                    wen_r  <= 1'b1;
                    if (psram_in.wait_n) begin
                        cen_r <= 1'b1;
                        st    <= lfbuf_psram_pkg::ST_DUMMY_RD;
                    end
                end
                lfbuf_psram_pkg::ST_DUMMY_RD: begin  // settles the new config
                    addr_r <= '0;
                    cen_r  <= 1'b0;
                    advn_r <= 1'b0;
                    st     <= lfbuf_psram_pkg::ST_DUMMY_WAIT;
                end
                lfbuf_psram_pkg::ST_DUMMY_WAIT: begin
                    advn_r <= 1'b1;
                    oen_r  <= 1'b0;
                    if (psram_in.wait_n) begin
                        oen_r <= 1'b1;
                        cen_r <= 1'b1;
                        st    <= lfbuf_psram_pkg::ST_IDLE;
                    end
                end
                lfbuf_psram_pkg::ST_IDLE: begin
                    if (do_rd) begin                // display line has priority
                        do_rd     <= 1'b0;
                        addr_r    <= {frame, vrender, {PAD{1'b0}}, {`LFBUF_HW{1'b0}}};
                        col       <= '0;
                        scan_busy <= 1'b1;
                        st        <= lfbuf_psram_pkg::ST_RD_START;
                    end else if (do_wr && !fb_clr && lhbl && wr_window) begin
                        addr_r  <= {!frame, wr_line, {PAD{1'b0}}, {`LFBUF_HW{1'b0}}};
                        col     <= '0;
                        fb_addr <= '0;
                        st      <= lfbuf_psram_pkg::ST_WR_START;
                    end
                end
                lfbuf_psram_pkg::ST_WR_START: begin
                    cen_r  <= 1'b0;
                    advn_r <= 1'b0;
                    wen_r  <= 1'b0;                 // write burst
                    st     <= lfbuf_psram_pkg::ST_WR_WAIT;
                end
                lfbuf_psram_pkg::ST_WR_WAIT: begin
                    advn_r <= 1'b1;
                    if (psram_in.wait_n) begin
                        fb_addr <= fb_addr + 1'b1;  // RAM runs one word ahead
                        st      <= lfbuf_psram_pkg::ST_WR_BURST;
                    end
                end
                lfbuf_psram_pkg::ST_WR_BURST: begin
                    col <= col + 1'b1;
                    if (!chunk_end) begin
                        fb_addr <= fb_addr + 1'b1;
                    end else begin
                        cen_r <= 1'b1;
                        wen_r <= 1'b1;
                        if (line_end) begin         // fb_addr has wrapped to 0
                            fb_clr  <= 1'b1;
                            fb_done <= 1'b1;
                            line    <= !line;
                            do_wr   <= 1'b0;
                            st      <= lfbuf_psram_pkg::ST_IDLE;
                        end else begin
                            st <= lfbuf_psram_pkg::ST_WR_BREAK;
                        end
                    end
                end
                lfbuf_psram_pkg::ST_WR_BREAK, lfbuf_psram_pkg::ST_RD_BREAK: begin
                    addr_r[`LFBUF_HW-1:0] <= col;   // next chunk column
                    st <= (st == lfbuf_psram_pkg::ST_WR_BREAK) ?
                          lfbuf_psram_pkg::ST_WR_START : lfbuf_psram_pkg::ST_RD_START;
                end
                lfbuf_psram_pkg::ST_RD_START: begin
                    cen_r  <= 1'b0;
                    advn_r <= 1'b0;
                    wen_r  <= 1'b1;                 // read burst
                    st     <= lfbuf_psram_pkg::ST_RD_WAIT;
                end
                lfbuf_psram_pkg::ST_RD_WAIT: begin
                    advn_r <= 1'b1;
                    oen_r  <= 1'b0;
                    if (psram_in.wait_n) st <= lfbuf_psram_pkg::ST_RD_BURST;
                end
                lfbuf_psram_pkg::ST_RD_BURST: begin
                    col <= col + 1'b1;
                    if (chunk_end) begin
                        cen_r <= 1'b1;
                        oen_r <= 1'b1;
                        if (line_end) begin
                            scan_busy <= 1'b0;
                            st        <= lfbuf_psram_pkg::ST_IDLE;
                        end else begin
                            st <= lfbuf_psram_pkg::ST_RD_BREAK;
                        end
                    end
                end
                default: st <= lfbuf_psram_pkg::ST_IDLE;
            endcase
            if (ln_done && !ln_done_l) do_wr <= 1'b1;   // new request wins
        end
    end

endmodule

//--- verilog/lfbuf_line_ram.sv
/* line RAM, one write port and one registered read port
   holds a single scanline of pixels */
`timescale 1ns/1ps
`include "lfbuf_settings.svh"

module lfbuf_line_ram (
    input  logic                      clk,
    input  lfbuf_video_pkg::line_wr_t wr,
    input  lfbuf_video_pkg::pix_idx_t rd_addr,
    output lfbuf_video_pkg::pixel_t   rd_data
);

    localparam int DEPTH = 2 ** `LFBUF_HW;          // 512 words

    lfbuf_video_pkg::pixel_t mem [DEPTH];

    // write side
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read side, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/lfbuf_hblank_timer.sv
/* horizontal blank timer
   measures the blank in pixels and flags when a line write may still start */
`timescale 1ns/1ps
`include "lfbuf_settings.svh"

module lfbuf_hblank_timer (
    input  logic clk,
    input  logic rst,
    input  logic pxl_cen,
    input  logic lhbl,
    output logic wr_window,
    output logic blank_start
);

    // one bit wider than the pixel index, total line exceeds 512
    localparam int CW = `LFBUF_HW + 1;

    logic [CW-1:0] hcnt;                            // pixels since blank start
    logic [CW-1:0] hblen;                           // blank length
    logic [CW-1:0] hlim;                            // last allowed write start
    logic          lhbl_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt   <= '0;
            hblen  <= '0;
            hlim   <= '0;                           // no window until first line seen
            lhbl_l <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= lhbl;
            hcnt   <= hcnt + 1'b1;
            if (lhbl_l && !lhbl) begin              // blank begins
                hcnt <= '0;
                hlim <= hcnt - hblen;               // line length minus blank
            end
            if (!lhbl_l && lhbl) begin              // blank ends
                hblen <= hcnt;
            end
        end
    end

    assign blank_start = pxl_cen && lhbl_l && !lhbl;   // single cycle
    assign wr_window   = lhbl && (hcnt < hlim);         // write ends before blank

endmodule

//--- verilog/lfbuf_psram_pkg.sv
/* PSRAM-side types for the line frame buffer
   bus structs, controller states, bus configuration word */
`include "lfbuf_settings.svh"

package lfbuf_psram_pkg;

    // controller to PSRAM, adq pad split into out/oe
    typedef struct packed {
        logic [5:0]  addr_hi;                       // address bits 21:16
        logic [15:0] adq;                           // muxed address / write data
        logic        adq_oe;                        // drive adq onto the pad
        logic        advn;                          // address valid, low
        logic        cen;                           // chip enable, low
        logic        oen;                           // output enable, low
        logic        wen;                           // write enable, low
        logic        cre;                           // config register access
    } psram_out_t;

    // PSRAM to controller
    typedef struct packed {
        logic [15:0] adq;                           // read data
        logic        wait_n;                        // 1 once the burst may move
    } psram_in_t;

    typedef enum logic [3:0] {
        ST_CFG, ST_CFG_WAIT, ST_DUMMY_RD, ST_DUMMY_WAIT, ST_IDLE,
        ST_WR_START, ST_WR_WAIT, ST_WR_BURST, ST_WR_BREAK,
        ST_RD_START, ST_RD_WAIT, ST_RD_BURST, ST_RD_BREAK
    } ctrl_state_t;

    localparam logic [1:0] BCR_SEL = 2'd2;          // bus configuration register

    localparam logic [21:0] BCR_WORD = {
        2'd0,                                       // reserved
        BCR_SEL,
        2'd0,                                       // reserved
        1'b0,                                       // synchronous burst
        1'b1,                                       // fixed latency
        3'(`LFBUF_LATENCY),
        1'b1,                                       // wait active high
        1'b0,                                       // reserved
        1'b1,                                       // wait one cycle ahead of data
        2'd0,                                       // reserved
        2'd1,                                       // drive strength
        1'b1,                                       // no wrap
        3'd7                                        // continuous burst
    };

endpackage

//--- verilog/lfbuf_video_pkg.sv
/* video-side types for the line frame buffer
   pixels, pixel and line indices, line RAM write port */
`include "lfbuf_settings.svh"

package lfbuf_video_pkg;

    typedef logic [15:0] pixel_t;                  // one 16-bit pixel

    typedef logic [`LFBUF_HW-1:0] pix_idx_t;        // column within a line

    typedef logic [`LFBUF_VW-1:0] line_idx_t;       // scanline number

    // write port of a line RAM
    typedef struct packed {
        pix_idx_t addr;                             // pixel position
        pixel_t   data;                             // pixel value
        logic     we;                               // write strobe
    } line_wr_t;

endpackage

//--- verilog/lfbuf_settings.svh
/* line frame buffer sizing
   line and row widths, PSRAM burst chunk and latency code */
`ifndef LFBUF_SETTINGS_SVH
`define LFBUF_SETTINGS_SVH

// pixel index width, 512 pixels per line
`define LFBUF_HW 9

// line index width, 256 lines per bank
`define LFBUF_VW 8

// words per burst before chip select is released
`define LFBUF_CHUNK 128

// fixed latency code written to the bus configuration register
`define LFBUF_LATENCY 3

`endif
